//--- design/mix_reg_file.sv
// APB slave for the mixing registers.
// Four-operator select, new-mode bit and per-channel pan and connection bits.
// Zero-wait-state readback and slave error on unmapped addresses.
// Resolves the new-mode rules into the mixing configuration.
`timescale 1ns/1ps

module mix_reg_file
    import opl3_mix_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb,
    output logic [7:0] prdata,
    output logic     pslverr,
    output mix_cfg_t cfg
);
    localparam logic [7:0] CHAN_LO = 8'(REG_CHAN_BASE);
    localparam logic [7:0] CHAN_HI = 8'(REG_CHAN_LAST);

    logic [NUM_BANKS*NUM_4OP-1:0] four_op_sel;
    logic                         new_mode;
    logic [NUM_SLOTS-1:0]         conn_raw;
    logic [NUM_SLOTS-1:0]         pan_l_raw;
    logic [NUM_SLOTS-1:0]         pan_r_raw;

    logic access;
    logic hit_four_op;
    logic hit_new_mode;
    logic hit_chan;
    slot_t chan_slot;
    logic [SLOT_IDX_WIDTH-1:0] chan_idx;
    logic [7:0] rdata_sel;

    assign access = apb.psel && apb.penable;

    assign hit_four_op = apb.paddr == REG_FOUR_OP_SEL;
    assign hit_new_mode = apb.paddr == REG_NEW_MODE;
    // Channel registers are mirrored in both banks.
    assign hit_chan = apb.paddr[7:0] >= CHAN_LO && apb.paddr[7:0] <= CHAN_HI;

    assign chan_slot = '{bank: apb.paddr[8], channel: apb.paddr[3:0]};
    assign chan_idx = slot_index(chan_slot);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            four_op_sel <= '0;
            new_mode <= 1'b0;
            conn_raw <= '0;
            pan_l_raw <= '0;
            pan_r_raw <= '0;
        end else if (access && apb.pwrite) begin
            if (hit_four_op)
                four_op_sel <= apb.pwdata[NUM_BANKS*NUM_4OP-1:0];
            if (hit_new_mode)
                new_mode <= apb.pwdata[0];
            if (hit_chan) begin
                conn_raw[chan_idx] <= apb.pwdata[0];
                pan_l_raw[chan_idx] <= apb.pwdata[4];
                pan_r_raw[chan_idx] <= apb.pwdata[5];
            end
        end
    end

    always_comb begin
        rdata_sel = '0;
        if (hit_four_op)
            rdata_sel = 8'(four_op_sel);
        else if (hit_new_mode)
            rdata_sel = {7'b0, new_mode};
        else if (hit_chan)
            rdata_sel = {2'b00, pan_r_raw[chan_idx], pan_l_raw[chan_idx], 3'b000,
                         conn_raw[chan_idx]};
    end

    assign prdata = (access && !apb.pwrite) ? rdata_sel : '0;
    assign pslverr = access && !(hit_four_op || hit_new_mode || hit_chan);

    // Four-operator pairing exists only in new mode.
    assign cfg.four_op = four_op_sel & {(NUM_BANKS*NUM_4OP){new_mode}};
    assign cfg.conn = conn_raw;
    // Old mode plays bank 0 on both sides regardless of pan.
    assign cfg.pan_l = pan_l_raw | {{NUM_CHANNELS{1'b0}}, {NUM_CHANNELS{!new_mode}}};
    assign cfg.pan_r = pan_r_raw | {{NUM_CHANNELS{1'b0}}, {NUM_CHANNELS{!new_mode}}};

endmodule

//--- design/mix_scan_fsm.sv
// Sample scan FSM.
// Issues the accumulator clear, the slot scan enable and the output latch.
`timescale 1ns/1ps

module mix_scan_fsm
    import opl3_mix_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic sample_start,
    input  logic last_slot,
    output logic scan_en,
    output logic clear,
    output logic latch,
    output logic sample_valid
);
    scan_state_e state;
    scan_state_e next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE:  if (sample_start) next_state = SCAN;
            SCAN:  if (last_slot) next_state = DRAIN;
            DRAIN: next_state = LATCH;
            LATCH: next_state = IDLE;
        endcase
    end

    // A start during a scan is dropped.
    assign clear = state == IDLE && sample_start;
    assign scan_en = state == SCAN;
    assign latch = state == LATCH;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= latch;
    end

endmodule

//--- design/mix_slot_counter.sv
// Slot counter for the sample scan.
// Walks channels 0 to 8 of bank 0 and then of bank 1.
`timescale 1ns/1ps

module mix_slot_counter
    import opl3_mix_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  scan_en,
    output slot_t slot,
    output logic  last_slot
);
    localparam logic [3:0] LAST_CHAN = 4'(NUM_CHANNELS - 1);

    assign last_slot = slot.bank && slot.channel == LAST_CHAN;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (!scan_en || last_slot) begin
            slot <= '0;
        end else if (slot.channel == LAST_CHAN) begin
            slot.bank <= 1'b1;
            slot.channel <= '0;
        end else begin
            slot.channel <= slot.channel + 4'd1;
        end
    end

endmodule

//--- design/op_connect.sv
// Operator connection network.
// Two-operator sum or serial output per channel, four-operator algorithms
// for the first three channels of each bank, one registered value per slot.
`timescale 1ns/1ps

module op_connect
    import opl3_mix_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    scan_en,
    input  slot_t                   slot,
    input  op_bank_t [NUM_BANKS-1:0] op_out,
    input  mix_cfg_t                cfg,
    output conn_sample_t            conn
);
    op_bank_t ops;
    logic [3:0] ch;
    logic [SLOT_IDX_WIDTH-1:0] idx;
    logic [4:0] pair_lo;
    logic [4:0] k;
    logic four_sel;
    op_sample_t op_lo;
    op_sample_t op_hi;
    op_sample_t op_k0;
    op_sample_t op_k3;
    op_sample_t op_k6;
    op_sample_t op_k9;
    logic signed [CONN_WIDTH-1:0] two_op_val;
    logic signed [CONN_WIDTH-1:0] four_op_val;

    always_comb begin
        ops = op_out[slot.bank];
        ch = slot.channel;
        idx = slot_index(slot);

        // Each group of three channels skips the next group's operators.
        if (ch < 4'd3)
            pair_lo = 5'(ch);
        else if (ch < 4'd6)
            pair_lo = 5'(ch) + 5'd3;
        else
            pair_lo = 5'(ch) + 5'd6;
        op_lo = ops[pair_lo];
        op_hi = ops[pair_lo + 5'd3];
        two_op_val = cfg.conn[idx] ? op_lo + op_hi : op_hi;

        k = 5'(ch[1:0]);
        op_k0 = ops[k];
        op_k3 = ops[k + 5'd3];
        op_k6 = ops[k + 5'd6];
        op_k9 = ops[k + 5'd9];

        four_sel = 1'b0;
        four_op_val = op_k9;
        if (ch < 4'(NUM_4OP)) begin
            four_sel = cfg.four_op[slot.bank ? 3'(ch) + 3'(NUM_4OP) : 3'(ch)];
            // Connection bits of channels k and k+3 pick the algorithm.
            unique case ({cfg.conn[idx], cfg.conn[idx + SLOT_IDX_WIDTH'(3)]})
                2'b00: four_op_val = op_k9;
                2'b01: four_op_val = op_k3 + op_k9;
                2'b10: four_op_val = op_k0 + op_k9;
                2'b11: four_op_val = op_k0 + op_k6 + op_k9;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conn <= '0;
        end else begin
            conn.valid <= scan_en;
            conn.slot <= slot;
            conn.value <= four_sel ? four_op_val : two_op_val;
        end
    end

endmodule

//--- design/opl3_mix_pkg.sv
// Shared definitions for the FM output mixing stage.
// Widths and counts of operators, channels and banks.
// APB request struct, register-address enum and scan-state enum.
// Slot, resolved mixing configuration and connected-sample structs.
// Slot index helper used by the register file and the datapath.
package opl3_mix_pkg;

    localparam int OP_OUT_WIDTH = 13;
    localparam int NUM_BANKS = 2;
    localparam int NUM_CHANNELS = 9;
    localparam int NUM_OPS = 18;
    localparam int NUM_4OP = 3;
    localparam int CONN_WIDTH = OP_OUT_WIDTH + 2;
    localparam int NUM_SLOTS = NUM_BANKS * NUM_CHANNELS;
    localparam int SLOT_IDX_WIDTH = $clog2(NUM_SLOTS);

    typedef logic signed [OP_OUT_WIDTH-1:0] op_sample_t;
    typedef op_sample_t [NUM_OPS-1:0] op_bank_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [8:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    // Bit 8 of the address selects the bank.
    typedef enum logic [8:0] {
        REG_CHAN_BASE   = 9'h0C0,
        REG_CHAN_LAST   = 9'h0C8,
        REG_FOUR_OP_SEL = 9'h104,
        REG_NEW_MODE    = 9'h105
    } reg_addr_e;

    typedef struct packed {
        logic       bank;
        logic [3:0] channel;
    } slot_t;

    // All enables are indexed by slot, bank 0 in the low bits.
    typedef struct packed {
        logic [NUM_BANKS*NUM_4OP-1:0] four_op;
        logic [NUM_SLOTS-1:0]         conn;
        logic [NUM_SLOTS-1:0]         pan_l;
        logic [NUM_SLOTS-1:0]         pan_r;
    } mix_cfg_t;

    typedef struct packed {
        logic                         valid;
        slot_t                        slot;
        logic signed [CONN_WIDTH-1:0] value;
    } conn_sample_t;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DRAIN,
        LATCH
    } scan_state_e;

    function automatic logic [SLOT_IDX_WIDTH-1:0] slot_index(slot_t s);
        logic [SLOT_IDX_WIDTH-1:0] chan;
        chan = SLOT_IDX_WIDTH'(s.channel);
        return s.bank ? chan + SLOT_IDX_WIDTH'(NUM_CHANNELS) : chan;
    endfunction

endpackage

//--- design/opl3_mixer_top.sv
// Top level of the FM output mixing stage.
// APB register file, scan FSM and slot counter, connection network,
// and left and right pan accumulators.
`timescale 1ns/1ps

module opl3_mixer_top
    import opl3_mix_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  apb_req_t                       apb,
    input  logic                           sample_start,
    input  op_bank_t [NUM_BANKS-1:0]       op_out,
    output logic [7:0]                     prdata,
    output logic                           pslverr,
    output logic                           sample_valid,
    output logic signed [SAMPLE_WIDTH-1:0] left,
    output logic signed [SAMPLE_WIDTH-1:0] right
);
    mix_cfg_t cfg;
    slot_t slot;
    conn_sample_t conn;
    logic last_slot;
    logic scan_en;
    logic clear;
    logic latch;

    mix_reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb     (apb),
        .prdata  (prdata),
        .pslverr (pslverr),
        .cfg     (cfg)
    );

    mix_scan_fsm u_scan_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .last_slot    (last_slot),
        .scan_en      (scan_en),
        .clear        (clear),
        .latch        (latch),
        .sample_valid (sample_valid)
    );

    mix_slot_counter u_slot_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_en   (scan_en),
        .slot      (slot),
        .last_slot (last_slot)
    );

    op_connect u_op_connect (
        .clk     (clk),
        .rst_n   (rst_n),
        .scan_en (scan_en),
        .slot    (slot),
        .op_out  (op_out),
        .cfg     (cfg),
        .conn    (conn)
    );

    pan_accumulator #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) u_left (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .latch  (latch),
        .conn   (conn),
        .pan    (cfg.pan_l),
        .sample (left)
    );

    pan_accumulator #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) u_right (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .latch  (latch),
        .conn   (conn),
        .pan    (cfg.pan_r),
        .sample (right)
    );

endmodule

//--- design/pan_accumulator.sv
// One output side of the mixer.
// Pan gating of each connected channel value, running sum over the scan,
// saturation to the signed sample width on latch.
`timescale 1ns/1ps

module pan_accumulator
    import opl3_mix_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clear,
    input  logic                           latch,
    input  conn_sample_t                   conn,
    input  logic [NUM_SLOTS-1:0]           pan,
    output logic signed [SAMPLE_WIDTH-1:0] sample
);
    // Enough headroom for eighteen full-scale channels.
    localparam int SUM_WIDTH = CONN_WIDTH + SLOT_IDX_WIDTH;
    localparam int ACC_WIDTH = SUM_WIDTH > SAMPLE_WIDTH ? SUM_WIDTH : SAMPLE_WIDTH + 1;

    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX =
        {{(ACC_WIDTH-SAMPLE_WIDTH+1){1'b0}}, {(SAMPLE_WIDTH-1){1'b1}}};
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN =
        {{(ACC_WIDTH-SAMPLE_WIDTH+1){1'b1}}, {(SAMPLE_WIDTH-1){1'b0}}};

    logic signed [ACC_WIDTH-1:0] sum;
    logic signed [ACC_WIDTH-1:0] addend;

    always_comb begin
        if (pan[slot_index(conn.slot)])
            addend = conn.value;
        else
            addend = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sum <= '0;
        else if (clear)
            sum <= '0;
        else if (conn.valid)
            sum <= sum + addend;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample <= '0;
        end else if (latch) begin
            if (sum > SAT_MAX)
                sample <= SAT_MAX[SAMPLE_WIDTH-1:0];
            else if (sum < SAT_MIN)
                sample <= SAT_MIN[SAMPLE_WIDTH-1:0];
            else
                sample <= sum[SAMPLE_WIDTH-1:0];
        end
    end

endmodule

//--- list.f
+incdir+verification
design/opl3_mix_pkg.sv
design/mix_reg_file.sv
design/mix_scan_fsm.sv
design/mix_slot_counter.sv
design/op_connect.sv
design/pan_accumulator.sv
design/opl3_mixer_top.sv
verification/tb_opl3_mixer.sv

//--- run.sh
#!/bin/sh
# Builds the mixer testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_opl3_mixer -f list.f \
    && ./obj_dir/Vtb_opl3_mixer 2>&1 | tee sim.log \
    && ! grep -q "Regression failed" sim.log \
    && grep -q "Regression passed" sim.log \
    || { echo "Simulation did not pass, see sim.log"; exit 1; }

//--- verification/mix_model.svh
// Reference model of the mixing stage for the testbench.
// Shadow copies of the mixing registers and of the operator outputs.
// Expected readback data and slave error for an APB address.
// Expected left and right samples from connection, pan, sum and clamp.
`ifndef MIX_MODEL_SVH
`define MIX_MODEL_SVH

logic [NUM_BANKS*NUM_4OP-1:0] sh_four_op;
logic                         sh_new_mode;
logic [NUM_SLOTS-1:0]         sh_conn;
logic [NUM_SLOTS-1:0]         sh_pan_l;
logic [NUM_SLOTS-1:0]         sh_pan_r;
op_bank_t [NUM_BANKS-1:0]     sh_ops;

function automatic bit is_chan_addr(input logic [8:0] addr);
    return addr[7:0] >= 8'hC0 && addr[7:0] <= 8'hC8;
endfunction

function automatic bit model_err(input logic [8:0] addr);
    return !(addr == REG_FOUR_OP_SEL || addr == REG_NEW_MODE || is_chan_addr(addr));
endfunction

function automatic int chan_slot(input logic [8:0] addr);
    return (addr[8] ? NUM_CHANNELS : 0) + int'(addr[3:0]);
endfunction

function automatic void model_write(input logic [8:0] addr, input logic [7:0] data);
    if (addr == REG_FOUR_OP_SEL) begin
        sh_four_op = data[NUM_BANKS*NUM_4OP-1:0];
    end else if (addr == REG_NEW_MODE) begin
        sh_new_mode = data[0];
    end else if (is_chan_addr(addr)) begin
        sh_conn[chan_slot(addr)] = data[0];
        sh_pan_l[chan_slot(addr)] = data[4];
        sh_pan_r[chan_slot(addr)] = data[5];
    end
endfunction

function automatic logic [7:0] model_read(input logic [8:0] addr);
    logic [7:0] value;
    value = '0;
    if (addr == REG_FOUR_OP_SEL) begin
        value[NUM_BANKS*NUM_4OP-1:0] = sh_four_op;
    end else if (addr == REG_NEW_MODE) begin
        value[0] = sh_new_mode;
    end else if (is_chan_addr(addr)) begin
        value[0] = sh_conn[chan_slot(addr)];
        value[4] = sh_pan_l[chan_slot(addr)];
        value[5] = sh_pan_r[chan_slot(addr)];
    end
    return value;
endfunction

function automatic int op_val(input int b, input int op);
    return int'($signed(sh_ops[b][op]));
endfunction

function automatic int chan_value(input int b, input int c);
    int base;
    int lo;
    int result;
    base = b * NUM_CHANNELS;
    // Pairs (c, c+3), (c+3, c+6) and (c+6, c+9) for the three groups.
    lo = c + 3 * (c / 3);
    if (sh_conn[base + c])
        result = op_val(b, lo) + op_val(b, lo + 3);
    else
        result = op_val(b, lo + 3);
    if (c < NUM_4OP && sh_new_mode && sh_four_op[b * NUM_4OP + c]) begin
        case ({sh_conn[base + c], sh_conn[base + c + 3]})
            2'b00: result = op_val(b, c + 9);
            2'b01: result = op_val(b, c + 3) + op_val(b, c + 9);
            2'b10: result = op_val(b, c) + op_val(b, c + 9);
            default: result = op_val(b, c) + op_val(b, c + 6) + op_val(b, c + 9);
        endcase
    end
    return result;
endfunction

function automatic logic signed [SAMPLE_W-1:0] model_side(input bit right_side);
    int sum;
    int s;
    bit pan;
    sum = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            s = b * NUM_CHANNELS + c;
            pan = right_side ? sh_pan_r[s] : sh_pan_l[s];
            // Old mode plays all of bank 0 on both sides.
            if (!sh_new_mode && b == 0)
                pan = 1'b1;
            if (pan)
                sum += chan_value(b, c);
        end
    end
    if (sum > SAMPLE_MAX)
        sum = SAMPLE_MAX;
    else if (sum < SAMPLE_MIN)
        sum = SAMPLE_MIN;
    return SAMPLE_W'(sum);
endfunction

`endif

//--- verification/tb_opl3_mixer.sv
// Testbench for the FM output mixing stage.
// Clock and reset, LFSR stimulus, APB access tasks and compare tasks.
// Register readback, old mode, new-mode pan, four-operator, clamp and scan timing runs.
// Watchdog bounding the run time.
`timescale 1ns/1ps

module tb_opl3_mixer
    import opl3_mix_pkg::*;
();
    localparam int SAMPLE_W = 16;
    localparam int SAMPLE_MAX = (1 << (SAMPLE_W - 1)) - 1;
    localparam int SAMPLE_MIN = -(1 << (SAMPLE_W - 1));
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int SCAN_LATENCY = 20;
    localparam int RUNS_PER_TEST = 4;
    localparam int NUM_RUNS = 3 * RUNS_PER_TEST + 3;
    localparam int NUM_UNMAPPED = 6;
    localparam int NUM_TESTS = 3 * (NUM_SLOTS + 2) + 2 * NUM_UNMAPPED
                             + NUM_RUNS * (NUM_SLOTS + 3);
    localparam logic [NUM_UNMAPPED-1:0][8:0] UNMAPPED =
        {9'h000, 9'h004, 9'h0BF, 9'h0C9, 9'h106, 9'h1D0};

    logic clk;
    logic rst_n;
    apb_req_t apb;
    logic sample_start;
    op_bank_t [NUM_BANKS-1:0] op_out;
    logic [7:0] prdata;
    logic pslverr;
    logic sample_valid;
    logic signed [SAMPLE_W-1:0] left;
    logic signed [SAMPLE_W-1:0] right;
    logic [31:0] lfsr_state;

    `include "mix_model.svh"

    opl3_mixer_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .apb          (apb),
        .sample_start (sample_start),
        .op_out       (op_out),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .sample_valid (sample_valid),
        .left         (left),
        .right        (right)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (NUM_TESTS * 30 + RESET_CYCLES));
        stop_on_error("watchdog expired before the regression finished");
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_sample(input string name, input logic signed [SAMPLE_W-1:0] exp,
                                input logic signed [SAMPLE_W-1:0] act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch %s expected %h got %h", name, exp, act));
    endtask

    task automatic check_rdata(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch %s expected %h got %h", name, exp, act));
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch %s expected %h got %h", name, exp, act));
    endtask

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[31]};
        end
        return value;
    endfunction

    function automatic logic [8:0] chan_addr(input int s);
        return {s >= NUM_CHANNELS, 8'hC0 + 8'(s % NUM_CHANNELS)};
    endfunction

    // Setup phase, access phase, then back to idle.
    task automatic apb_access(input logic write, input logic [8:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata,
                              output logic err);
        @(posedge clk);
        apb <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        apb <= '0;
        if (write)
            model_write(addr, wdata);
    endtask

    task automatic write_reg(input logic [8:0] addr, input logic [7:0] data);
        logic [7:0] rdata;
        logic err;
        apb_access(1'b1, addr, data, rdata, err);
        check_err($sformatf("pslverr on write to %h", addr), model_err(addr), err);
    endtask

    task automatic read_check(input logic [8:0] addr);
        logic [7:0] rdata;
        logic err;
        apb_access(1'b0, addr, 8'h00, rdata, err);
        check_err($sformatf("pslverr on read of %h", addr), model_err(addr), err);
        if (!model_err(addr))
            check_rdata($sformatf("prdata at %h", addr), model_read(addr), rdata);
    endtask

    // Pan kind 0 is random, 1 gives equal left and right, 2 turns everything on.
    task automatic program_regs(input logic new_mode, input logic [5:0] four_op,
                                input int pan_kind);
        logic [7:0] data;
        write_reg(REG_NEW_MODE, {7'b0, new_mode});
        write_reg(REG_FOUR_OP_SEL, {2'b00, four_op});
        for (int s = 0; s < NUM_SLOTS; s++) begin
            data = 8'(take_bits(8));
            if (pan_kind == 1)
                data[5] = data[4];
            if (pan_kind == 2)
                data = 8'h31;
            write_reg(chan_addr(s), data);
        end
    endtask

    // Fill 0 gives random operators, positive full scale, negative most negative.
    task automatic drive_ops(input int fill);
        op_bank_t [NUM_BANKS-1:0] ops;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                if (fill > 0)
                    ops[b][i] = {1'b0, {(OP_OUT_WIDTH-1){1'b1}}};
                else if (fill < 0)
                    ops[b][i] = {1'b1, {(OP_OUT_WIDTH-1){1'b0}}};
                else
                    ops[b][i] = OP_OUT_WIDTH'(take_bits(OP_OUT_WIDTH));
            end
        end
        @(posedge clk);
        op_out <= ops;
        sh_ops = ops;
    endtask

    task automatic run_sample(input string tag, input bit restart_mid_scan);
        int cycles;
        @(posedge clk);
        sample_start <= 1'b1;
        @(posedge clk);
        sample_start <= 1'b0;
        // The DUT accepted the start on this edge.
        cycles = 0;
        @(negedge clk);
        while (!sample_valid) begin
            if (cycles > 2 * SCAN_LATENCY)
                stop_on_error($sformatf("%s: sample_valid never came after sample_start", tag));
            @(posedge clk);
            cycles++;
            if (restart_mid_scan)
                sample_start <= (cycles == 5);
            @(negedge clk);
        end
        if (cycles != SCAN_LATENCY)
            stop_on_error($sformatf("mismatch %s latency expected %h got %h", tag,
                                    SCAN_LATENCY, cycles));
        check_sample($sformatf("left in %s", tag), model_side(1'b0), left);
        check_sample($sformatf("right in %s", tag), model_side(1'b1), right);
        @(posedge clk);
        @(negedge clk);
        if (sample_valid)
            stop_on_error($sformatf("%s: sample_valid stayed high for a second cycle", tag));
    endtask

    initial begin
        lfsr_state = 32'he425;
        rst_n = 1'b0;
        apb = '0;
        sample_start = 1'b0;
        op_out = '0;
        sh_ops = '0;
        sh_four_op = '0;
        sh_new_mode = 1'b0;
        sh_conn = '0;
        sh_pan_l = '0;
        sh_pan_r = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (sample_valid)
            stop_on_error("sample_valid was high right after reset");
        check_sample("left after reset", '0, left);
        check_sample("right after reset", '0, right);

        // Readback of every mapped register, then the error response.
        write_reg(REG_FOUR_OP_SEL, 8'(take_bits(8)));
        read_check(REG_FOUR_OP_SEL);
        write_reg(REG_NEW_MODE, 8'(take_bits(8)));
        read_check(REG_NEW_MODE);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            write_reg(chan_addr(s), 8'(take_bits(8)));
            read_check(chan_addr(s));
        end
        for (int u = 0; u < NUM_UNMAPPED; u++) begin
            write_reg(UNMAPPED[u], 8'(take_bits(8)));
            read_check(UNMAPPED[u]);
        end

        // Every mapped register still holds its own value after all other writes.
        read_check(REG_FOUR_OP_SEL);
        read_check(REG_NEW_MODE);
        for (int s = 0; s < NUM_SLOTS; s++)
            read_check(chan_addr(s));

        for (int i = 0; i < RUNS_PER_TEST; i++) begin
            program_regs(1'b0, 6'(take_bits(6)), 1);
            drive_ops(0);
            run_sample("old mode", 1'b0);
        end
        for (int i = 0; i < RUNS_PER_TEST; i++) begin
            program_regs(1'b1, 6'b0, 0);
            drive_ops(0);
            run_sample("new-mode pan", 1'b0);
        end
        for (int i = 0; i < RUNS_PER_TEST; i++) begin
            program_regs(1'b1, 6'(take_bits(6)), 0);
            drive_ops(0);
            run_sample("four-op", 1'b0);
        end

        // Full-scale operators on every slot.
        program_regs(1'b1, 6'b0, 2);
        drive_ops(1);
        run_sample("positive clamp", 1'b0);
        check_sample("left positive clamp", SAMPLE_W'(SAMPLE_MAX), left);
        check_sample("right positive clamp", SAMPLE_W'(SAMPLE_MAX), right);
        drive_ops(-1);
        run_sample("negative clamp", 1'b0);
        check_sample("left negative clamp", SAMPLE_W'(SAMPLE_MIN), left);
        check_sample("right negative clamp", SAMPLE_W'(SAMPLE_MIN), right);

        // A second start in the middle of the scan must be dropped.
        program_regs(1'b1, 6'b0, 0);
        drive_ops(0);
        run_sample("scan timing", 1'b1);
        repeat (SCAN_LATENCY + 5) begin
            @(negedge clk);
            if (sample_valid)
                stop_on_error("extra sample_valid after a start issued during the scan");
        end

        $display("Regression passed");
        $finish;
    end

endmodule
